// ==== axi4s_pkg.sv ====
// Shared widths and encodings for the packet filter and its statistics.
// Counters are CNT_WID bits wide and wrap silently on overflow.
// The tuser mode only matters to the discard block. Probes ignore it.

package axi4s_pkg;

   // ------------------------------------------------------------
   // stream interpretation
   // ------------------------------------------------------------

   // how the single tuser bit of a stream is read.
   // in USER mode the bit is carried through and never acted on.
   typedef enum {
      USER,
      PKT_ERROR
   } axi4s_tuser_mode_t;

   // what a probe counts.
   // ERRORS mode only counts beats whose tuser flag is high.
   typedef enum {
      PACKETS,
      ERRORS
   } axi4s_probe_mode_t;

   // ------------------------------------------------------------
   // statistics port
   // ------------------------------------------------------------

   typedef enum logic [1:0] {
      STATS_NOP,
      STATS_READ,
      STATS_CLEAR
   } stats_op_t;

   // the four readable counters, in address order.
   typedef enum logic [1:0] {
      REG_OUT_PKTS,
      REG_OUT_BYTES,
      REG_ERR_PKTS,
      REG_ERR_BYTES
   } stats_addr_t;

   localparam int CNT_WID = 32;

   typedef logic [CNT_WID-1:0] cnt_t;

endpackage

// ==== axi4s_probe.sv ====
// Packet and byte counters for an accepted beat stream.
// Bytes are the set bits of tkeep, so holes in tkeep are not counted.
// Counters wrap. cnt_clr wins over a beat counted in the same cycle.

module axi4s_probe
   import axi4s_pkg::*;
#(
   parameter int                DATA_BYTE_WID = 8,
   parameter axi4s_probe_mode_t MODE          = PACKETS
) (
   input  logic                     axi4s_in_if,
   input  logic                     srst,
   input  logic                     beat,
   input  logic [DATA_BYTE_WID-1:0] tkeep,
   input  logic                     tlast,
   input  logic                     tuser,
   input  logic                     cnt_clr,
   output cnt_t                     pkt_cnt,
   output cnt_t                     byte_cnt
);

   // wide enough to hold a full tkeep count.
   localparam int KEEP_CNT_WID = $clog2(DATA_BYTE_WID + 1);

   logic                    counted;
   logic [KEEP_CNT_WID-1:0] beat_bytes;

   // population count of the tkeep lanes.
   function automatic logic [KEEP_CNT_WID-1:0] count_ones(
      input logic [DATA_BYTE_WID-1:0] keep
   );
      logic [KEEP_CNT_WID-1:0] n;
      n = '0;
      for (int i = 0; i < DATA_BYTE_WID; i++) begin
         n = n + KEEP_CNT_WID'(keep[i]);
      end
      return n;
   endfunction

   // ------------------------------------------------------------
   // beat qualification
   // ------------------------------------------------------------

   // in PACKETS mode every accepted beat counts.
   // in ERRORS mode the tuser flag must also be set.
   assign counted = beat && ((MODE == PACKETS) || tuser);

   assign beat_bytes = count_ones(tkeep);

   // ------------------------------------------------------------
   // counters
   // ------------------------------------------------------------

   // a packet is counted on its tlast beat.
   // the new values show one cycle after the beat's edge.
   always_ff @(posedge axi4s_in_if) begin
      if (srst || cnt_clr) begin
         pkt_cnt  <= '0;
         byte_cnt <= '0;
      end else if (counted) begin
         byte_cnt <= byte_cnt + cnt_t'(beat_bytes);
         if (tlast) begin
            pkt_cnt <= pkt_cnt + cnt_t'(1);
         end
      end
   end

endmodule

// ==== axi4s_pkt_discard_err.sv ====
// Drops a whole packet when tuser is set on its first beat (PKT_ERROR mode only).
// Zero latency. tready is passed straight back, so there is no buffering.
// tuser on later beats of a packet never causes a discard.

module axi4s_pkt_discard_err
   import axi4s_pkg::*;
#(
   parameter int                DATA_BYTE_WID = 8,
   parameter axi4s_tuser_mode_t TUSER_MODE    = USER
) (
   input  logic                         axi4s_in_if,
   input  logic                         srst,
   input  logic                         in_tvalid,
   output logic                         in_tready,
   input  logic [8*DATA_BYTE_WID-1:0]   in_tdata,
   input  logic [DATA_BYTE_WID-1:0]     in_tkeep,
   input  logic                         in_tlast,
   input  logic                         in_tuser,
   output logic                         out_tvalid,
   input  logic                         out_tready,
   output logic [8*DATA_BYTE_WID-1:0]   out_tdata,
   output logic [DATA_BYTE_WID-1:0]     out_tkeep,
   output logic                         out_tlast,
   output logic                         out_tuser,
   input  logic                         cnt_clr,
   output cnt_t                         err_pkts,
   output cnt_t                         err_bytes
);

   logic in_beat;
   logic sop_in;
   logic err_first;
   logic err_pkt;
   logic drop_beat;

   // a beat moves on the input when both sides agree.
   assign in_beat = in_tvalid && in_tready;

   // ------------------------------------------------------------
   // start of packet and discard state
   // ------------------------------------------------------------

   // sop_in is high while the next accepted beat opens a new packet.
   always_ff @(posedge axi4s_in_if) begin
      if (srst) begin
         sop_in <= 1'b1;
      end else if (in_beat) begin
         sop_in <= in_tlast;
      end
   end

   // the first beat carries the error flag.
   // this does not look at tready, so out_tvalid stays stable under back-pressure.
   assign err_first = in_tvalid && sop_in && (TUSER_MODE == PKT_ERROR) && in_tuser;

   // err_pkt covers the remaining beats of an errored packet up to its tlast.
   // a single-beat errored packet is fully handled by err_first.
   always_ff @(posedge axi4s_in_if) begin
      if (srst) begin
         err_pkt <= 1'b0;
      end else if (err_pkt && in_beat && in_tlast) begin
         err_pkt <= 1'b0;
      end else if (err_first && in_beat && !in_tlast) begin
         err_pkt <= 1'b1;
      end
   end

   assign drop_beat = err_first || err_pkt;

   // ------------------------------------------------------------
   // stream path
   // ------------------------------------------------------------

   // dropped beats are still consumed upstream at the downstream rate.
   assign in_tready  = out_tready;
   assign out_tvalid = in_tvalid && !drop_beat;
   assign out_tdata  = in_tdata;
   assign out_tkeep  = in_tkeep;
   assign out_tlast  = in_tlast;
   assign out_tuser  = in_tuser;

   // the error probe sees every input beat, flagged for the whole dropped packet.
   axi4s_probe #(
      .DATA_BYTE_WID (DATA_BYTE_WID),
      .MODE          (ERRORS)
   ) u_err_probe (
      .axi4s_in_if (axi4s_in_if),
      .srst        (srst),
      .beat        (in_beat),
      .tkeep       (in_tkeep),
      .tlast       (in_tlast),
      .tuser       (drop_beat),
      .cnt_clr     (cnt_clr),
      .pkt_cnt     (err_pkts),
      .byte_cnt    (err_bytes)
   );

endmodule

// ==== axi4s_stats_regs.sv ====
// Opcode port for the four statistics counters.
// A read returns the value sampled at the op edge, one cycle later.
// A clear raises cnt_clr for one cycle and the counters read zero after it.

module axi4s_stats_regs
   import axi4s_pkg::*;
(
   input  logic        axi4s_in_if,
   input  logic        srst,
   input  stats_op_t   stats_op,
   input  stats_addr_t stats_addr,
   input  cnt_t        out_pkts,
   input  cnt_t        out_bytes,
   input  cnt_t        err_pkts,
   input  cnt_t        err_bytes,
   output cnt_t        stats_rdata,
   output logic        stats_rvalid,
   output logic        cnt_clr
);

   cnt_t rd_mux;

   // ------------------------------------------------------------
   // read path
   // ------------------------------------------------------------

   // select the addressed counter.
   always_comb begin
      unique case (stats_addr)
         REG_OUT_PKTS:  rd_mux = out_pkts;
         REG_OUT_BYTES: rd_mux = out_bytes;
         REG_ERR_PKTS:  rd_mux = err_pkts;
         REG_ERR_BYTES: rd_mux = err_bytes;
      endcase
   end

   // read data only changes on a read, so it holds between reads.
   always_ff @(posedge axi4s_in_if) begin
      if (stats_op == STATS_READ) begin
         stats_rdata <= rd_mux;
      end
   end

   // ------------------------------------------------------------
   // control
   // ------------------------------------------------------------

   // rvalid and cnt_clr are single-cycle pulses from a one-cycle op.
   always_ff @(posedge axi4s_in_if) begin
      if (srst) begin
         stats_rvalid <= 1'b0;
         cnt_clr      <= 1'b0;
      end else begin
         stats_rvalid <= (stats_op == STATS_READ);
         cnt_clr      <= (stats_op == STATS_CLEAR);
      end
   end

endmodule

// ==== axi4s_pkt_filter.sv ====
// Top level of the packet filter with delivered and discarded traffic counters.
// The stream path is combinational end to end and adds no latency.

module axi4s_pkt_filter
   import axi4s_pkg::*;
#(
   parameter int                DATA_BYTE_WID = 8,
   parameter axi4s_tuser_mode_t TUSER_MODE    = PKT_ERROR
) (
   input  logic                         axi4s_in_if,
   input  logic                         srst,
   input  logic                         in_tvalid,
   output logic                         in_tready,
   input  logic [8*DATA_BYTE_WID-1:0]   in_tdata,
   input  logic [DATA_BYTE_WID-1:0]     in_tkeep,
   input  logic                         in_tlast,
   input  logic                         in_tuser,
   output logic                         out_tvalid,
   input  logic                         out_tready,
   output logic [8*DATA_BYTE_WID-1:0]   out_tdata,
   output logic [DATA_BYTE_WID-1:0]     out_tkeep,
   output logic                         out_tlast,
   output logic                         out_tuser,
   input  stats_op_t                    stats_op,
   input  stats_addr_t                  stats_addr,
   output cnt_t                         stats_rdata,
   output logic                         stats_rvalid
);

   // counter values and the shared clear pulse.
   cnt_t out_pkts;
   cnt_t out_bytes;
   cnt_t err_pkts;
   cnt_t err_bytes;
   logic cnt_clr;

   // the discard block holds the error probe for dropped traffic.
   axi4s_pkt_discard_err #(
      .DATA_BYTE_WID (DATA_BYTE_WID),
      .TUSER_MODE    (TUSER_MODE)
   ) u_discard (
      .axi4s_in_if (axi4s_in_if),
      .srst        (srst),
      .in_tvalid   (in_tvalid),
      .in_tready   (in_tready),
      .in_tdata    (in_tdata),
      .in_tkeep    (in_tkeep),
      .in_tlast    (in_tlast),
      .in_tuser    (in_tuser),
      .out_tvalid  (out_tvalid),
      .out_tready  (out_tready),
      .out_tdata   (out_tdata),
      .out_tkeep   (out_tkeep),
      .out_tlast   (out_tlast),
      .out_tuser   (out_tuser),
      .cnt_clr     (cnt_clr),
      .err_pkts    (err_pkts),
      .err_bytes   (err_bytes)
   );

   // the output probe counts every beat delivered downstream.
   axi4s_probe #(
      .DATA_BYTE_WID (DATA_BYTE_WID),
      .MODE          (PACKETS)
   ) u_out_probe (
      .axi4s_in_if (axi4s_in_if),
      .srst        (srst),
      .beat        (out_tvalid && out_tready),
      .tkeep       (out_tkeep),
      .tlast       (out_tlast),
      .tuser       (out_tuser),
      .cnt_clr     (cnt_clr),
      .pkt_cnt     (out_pkts),
      .byte_cnt    (out_bytes)
   );

   axi4s_stats_regs u_stats (
      .axi4s_in_if  (axi4s_in_if),
      .srst         (srst),
      .stats_op     (stats_op),
      .stats_addr   (stats_addr),
      .out_pkts     (out_pkts),
      .out_bytes    (out_bytes),
      .err_pkts     (err_pkts),
      .err_bytes    (err_bytes),
      .stats_rdata  (stats_rdata),
      .stats_rvalid (stats_rvalid),
      .cnt_clr      (cnt_clr)
   );

endmodule

// ==== tb_axi4s_pkt_filter_assertions.sv ====
// Protocol checks on the discard block.
// The stability rule assumes the upstream side holds a beat until it is accepted.

module tb_axi4s_pkt_filter_assertions #(
   parameter int DATA_BYTE_WID = 8
) (
   input logic                       axi4s_in_if,
   input logic                       srst,
   input logic                       in_tvalid,
   input logic                       in_tready,
   input logic                       out_tvalid,
   input logic                       out_tready,
   input logic [8*DATA_BYTE_WID-1:0] out_tdata,
   input logic [DATA_BYTE_WID-1:0]   out_tkeep,
   input logic                       out_tlast,
   input logic                       out_tuser,
   input logic                       cnt_clr
);

   timeunit 1ns;
   timeprecision 1ps;

   // number of assertion failures so far.
   int unsigned assert_errs = 0;

   // tready is passed straight back to the input.
   ready_pass: assert property (@(posedge axi4s_in_if) disable iff (srst)
      in_tready == out_tready)
      else begin
         assert_errs++;
         $error("in_tready differs from out_tready");
      end

   // the filter can only remove beats, never create them.
   valid_gated: assert property (@(posedge axi4s_in_if) disable iff (srst)
      out_tvalid |-> in_tvalid)
      else begin
         assert_errs++;
         $error("out_tvalid is high while in_tvalid is low");
      end

   // a stalled output beat keeps its valid and its payload.
   stall_stable: assert property (@(posedge axi4s_in_if) disable iff (srst)
      (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata) &&
      $stable(out_tkeep) && $stable(out_tlast) && $stable(out_tuser)))
      else begin
         assert_errs++;
         $error("output beat changed while stalled");
      end

   // the clear pulse lasts exactly one cycle.
   clr_pulse: assert property (@(posedge axi4s_in_if) disable iff (srst)
      cnt_clr |=> !cnt_clr)
      else begin
         assert_errs++;
         $error("cnt_clr is high for more than one cycle");
      end

endmodule

// ==== tb_axi4s_pkt_filter.sv ====
// Random traffic for the packet filter, checked beat by beat against a queue model.
// Runs with TUSER_MODE set to PKT_ERROR and 8 data bytes per beat.
// The upstream side holds each beat until it is accepted, as the stream rules require.

module tb_axi4s_pkt_filter
   import axi4s_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int DATA_BYTE_WID  = 8;
   localparam int CLK_PERIOD     = 100;
   localparam int NUM_PKTS       = 300;
   localparam int MAX_BEATS      = 8;
   localparam int TIMEOUT_CYCLES = NUM_PKTS * MAX_BEATS * 4 + 2000;

   // one stream beat as it is driven and as it is expected at the output.
   typedef struct packed {
      logic [8*DATA_BYTE_WID-1:0] tdata;
      logic [DATA_BYTE_WID-1:0]   tkeep;
      logic                       tlast;
      logic                       tuser;
   } beat_t;

   logic                       axi4s_in_if;
   logic                       srst;
   logic                       in_tvalid;
   logic                       in_tready;
   logic [8*DATA_BYTE_WID-1:0] in_tdata;
   logic [DATA_BYTE_WID-1:0]   in_tkeep;
   logic                       in_tlast;
   logic                       in_tuser;
   logic                       out_tvalid;
   logic                       out_tready;
   logic [8*DATA_BYTE_WID-1:0] out_tdata;
   logic [DATA_BYTE_WID-1:0]   out_tkeep;
   logic                       out_tlast;
   logic                       out_tuser;
   stats_op_t                  stats_op;
   stats_addr_t                stats_addr;
   cnt_t                       stats_rdata;
   logic                       stats_rvalid;

   int    seed   = 32'h6e03_2785;
   int    cycles = 0;
   beat_t in_q[$];
   beat_t exp_q[$];
   cnt_t  exp_out_pkts  = '0;
   cnt_t  exp_out_bytes = '0;
   cnt_t  exp_err_pkts  = '0;
   cnt_t  exp_err_bytes = '0;

   axi4s_pkt_filter #(
      .DATA_BYTE_WID (DATA_BYTE_WID),
      .TUSER_MODE    (PKT_ERROR)
   ) i_dut (
      .axi4s_in_if  (axi4s_in_if),
      .srst         (srst),
      .in_tvalid    (in_tvalid),
      .in_tready    (in_tready),
      .in_tdata     (in_tdata),
      .in_tkeep     (in_tkeep),
      .in_tlast     (in_tlast),
      .in_tuser     (in_tuser),
      .out_tvalid   (out_tvalid),
      .out_tready   (out_tready),
      .out_tdata    (out_tdata),
      .out_tkeep    (out_tkeep),
      .out_tlast    (out_tlast),
      .out_tuser    (out_tuser),
      .stats_op     (stats_op),
      .stats_addr   (stats_addr),
      .stats_rdata  (stats_rdata),
      .stats_rvalid (stats_rvalid)
   );

   bind axi4s_pkt_discard_err tb_axi4s_pkt_filter_assertions #(
      .DATA_BYTE_WID (DATA_BYTE_WID)
   ) u_assertions (
      .axi4s_in_if (axi4s_in_if),
      .srst        (srst),
      .in_tvalid   (in_tvalid),
      .in_tready   (in_tready),
      .out_tvalid  (out_tvalid),
      .out_tready  (out_tready),
      .out_tdata   (out_tdata),
      .out_tkeep   (out_tkeep),
      .out_tlast   (out_tlast),
      .out_tuser   (out_tuser),
      .cnt_clr     (cnt_clr)
   );

   initial begin
      axi4s_in_if = 1'b0;
      forever #(CLK_PERIOD / 2) axi4s_in_if = ~axi4s_in_if;
   end

   // ------------------------------------------------------------
   // watchdog
   // ------------------------------------------------------------

   // the limit allows four cycles per beat of the longest possible traffic.
   always @(negedge axi4s_in_if) begin
      cycles = cycles + 1;
      if (i_dut.u_discard.u_assertions.assert_errs != 0) begin
         $display("a protocol assertion on the discard block failed");
         $display("TEST FAILED");
         $fatal(1, "assertion failure");
      end else if (cycles >= TIMEOUT_CYCLES) begin
         $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   // ------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------

   // beat fields print in the order data, keep, last, user.
   task automatic check_beat(input string name, input int num, input beat_t exp,
                             input logic [8*DATA_BYTE_WID-1:0] tdata,
                             input logic [DATA_BYTE_WID-1:0] tkeep,
                             input logic tlast, input logic tuser);
      if ({tdata, tkeep, tlast, tuser} !== exp) begin
         $display("** Error %s beat %0d: expected %h %h %b %b, actual %h %h %b %b",
                  name, num, exp.tdata, exp.tkeep, exp.tlast, exp.tuser,
                  tdata, tkeep, tlast, tuser);
         $display("TEST FAILED");
         $fatal(1, "beat mismatch");
      end
   endtask

   task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
      if (act !== exp) begin
         $display("** Error %s: expected %0d, actual %0d", name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "counter mismatch");
      end
   endtask

   // ------------------------------------------------------------
   // statistics port
   // ------------------------------------------------------------

   // the op is held for one cycle and rvalid must follow on the next.
   // rvalid is a one-cycle pulse, so it is low again before each new read.
   task automatic read_counter(input stats_addr_t addr, output cnt_t value);
      @(negedge axi4s_in_if);
      if (stats_rvalid !== 1'b0) begin
         $display("stats_rvalid is still high before a read of %s", addr.name());
         $display("TEST FAILED");
         $fatal(1, "stuck read response");
      end
      stats_op   = STATS_READ;
      stats_addr = addr;
      @(negedge axi4s_in_if);
      stats_op = STATS_NOP;
      if (stats_rvalid !== 1'b1) begin
         $display("stats_rvalid did not rise in the cycle after a read of %s", addr.name());
         $display("TEST FAILED");
         $fatal(1, "missing read response");
      end else begin
         value = stats_rdata;
      end
   endtask

   task automatic check_counters(input string name, input cnt_t op, input cnt_t ob,
                                 input cnt_t ep, input cnt_t eb);
      cnt_t value;
      read_counter(REG_OUT_PKTS, value);
      check_cnt({name, " out_pkts"}, op, value);
      read_counter(REG_OUT_BYTES, value);
      check_cnt({name, " out_bytes"}, ob, value);
      read_counter(REG_ERR_PKTS, value);
      check_cnt({name, " err_pkts"}, ep, value);
      read_counter(REG_ERR_BYTES, value);
      check_cnt({name, " err_bytes"}, eb, value);
   endtask

   // cnt_clr lands one cycle after the op, so one idle cycle follows it.
   task automatic clear_counters();
      @(negedge axi4s_in_if);
      stats_op = STATS_CLEAR;
      @(negedge axi4s_in_if);
      stats_op = STATS_NOP;
      @(negedge axi4s_in_if);
   endtask

   // ------------------------------------------------------------
   // traffic and model
   // ------------------------------------------------------------

   // errored packets go to the error totals, all others to the output queue.
   task automatic build_traffic();
      int    n_beats;
      logic  err;
      beat_t b;
      for (int p = 0; p < NUM_PKTS; p++) begin
         n_beats = 1 + ($random(seed) & (MAX_BEATS - 1));
         err     = ($random(seed) & 3) == 0;
         for (int i = 0; i < n_beats; i++) begin
            b.tdata = {$random(seed), $random(seed)};
            b.tlast = (i == n_beats - 1);
            b.tkeep = b.tlast ? DATA_BYTE_WID'($random(seed)) : '1;
            b.tuser = (i == 0) ? err : 1'($random(seed));
            in_q.push_back(b);
            if (err) begin
               exp_err_bytes += cnt_t'($countones(b.tkeep));
               exp_err_pkts  += cnt_t'(b.tlast);
            end else begin
               exp_q.push_back(b);
               exp_out_bytes += cnt_t'($countones(b.tkeep));
               exp_out_pkts  += cnt_t'(b.tlast);
            end
         end
      end
   endtask

   // outputs are sampled a quarter period after the falling edge, where they are settled.
   task automatic run_traffic();
      int    idx;
      int    n_out;
      logic  took;
      beat_t b;
      idx   = 0;
      n_out = 0;
      took  = 1'b0;
      while (idx < in_q.size()) begin
         @(negedge axi4s_in_if);
         if (took) begin
            idx++;
            in_tvalid = 1'b0;
         end
         if (!in_tvalid && idx < in_q.size() && ($random(seed) & 3) != 0) begin
            b         = in_q[idx];
            in_tvalid = 1'b1;
            in_tdata  = b.tdata;
            in_tkeep  = b.tkeep;
            in_tlast  = b.tlast;
            in_tuser  = b.tuser;
         end
         out_tready = ($random(seed) & 3) != 0;
         #(CLK_PERIOD / 4);
         if (out_tvalid && out_tready) begin
            if (exp_q.size() == 0) begin
               $display("a beat left the filter when none was expected");
               $display("TEST FAILED");
               $fatal(1, "extra beat");
            end else begin
               check_beat("traffic", n_out, exp_q.pop_front(),
                          out_tdata, out_tkeep, out_tlast, out_tuser);
               n_out++;
            end
         end
         took = in_tvalid && in_tready;
      end
   endtask

   initial begin
      srst       = 1'b1;
      in_tvalid  = 1'b0;
      in_tdata   = '0;
      in_tkeep   = '0;
      in_tlast   = 1'b0;
      in_tuser   = 1'b0;
      out_tready = 1'b0;
      stats_op   = STATS_NOP;
      stats_addr = REG_OUT_PKTS;
      repeat (16) @(posedge axi4s_in_if);
      @(negedge axi4s_in_if);
      srst = 1'b0;
      if (stats_rvalid !== 1'b0) begin
         $display("stats_rvalid is high after reset");
         $display("TEST FAILED");
         $fatal(1, "reset state");
      end
      check_counters("reset", '0, '0, '0, '0);
      build_traffic();
      run_traffic();
      check_counters("traffic", exp_out_pkts, exp_out_bytes, exp_err_pkts, exp_err_bytes);
      clear_counters();
      check_counters("clear", '0, '0, '0, '0);
      if (exp_q.size() != 0) begin
         $display("%0d expected beats never left the filter", exp_q.size());
         $display("TEST FAILED");
         $fatal(1, "missing beats");
      end else if (i_dut.u_discard.u_assertions.assert_errs != 0) begin
         $display("a protocol assertion on the discard block failed");
         $display("TEST FAILED");
         $fatal(1, "assertion failure");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

// ==== vlog.f ====
axi4s_pkg.sv
axi4s_probe.sv
axi4s_pkt_discard_err.sv
axi4s_stats_regs.sv
axi4s_pkt_filter.sv
tb_axi4s_pkt_filter_assertions.sv
tb_axi4s_pkt_filter.sv

// ==== Makefile ====
# Verilator flow for the packet filter testbench.
# The simulation exit status carries pass or fail.

TOP := tb_axi4s_pkt_filter
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP)
	verilator --lint-only --timescale 1ns/1ps \
		axi4s_pkg.sv axi4s_probe.sv axi4s_pkt_discard_err.sv \
		axi4s_stats_regs.sv axi4s_pkt_filter.sv --top-module axi4s_pkt_filter

$(OBJ)/V$(TOP): vlog.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP) -Mdir $(OBJ)

sim: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf $(OBJ)
